// ==== logic/dm_cache_pkg.sv ====
package dm_cache_pkg;

    // Processor side
    localparam int ADDR_W     = 16;   // Byte address
    localparam int WORD_W     = 16;

    // Address split, bit 0 dropped
    localparam int TAG_W      = 5;    // addr[15:11]
    localparam int INDEX_W    = 8;    // addr[10:3]
    localparam int OFFSET_W   = 2;    // addr[2:1]

    // Line geometry
    localparam int LINE_WORDS = 4;    // Also the bank count
    localparam int NUM_LINES  = 256;

    // Main memory
    localparam int MEM_ADDR_W = 15;   // Word address, tag+index+offset
    localparam int BANK_DEPTH = 8192; // 2**(TAG_W+INDEX_W)
    localparam int MEM_LATENCY = 4;   // Busy time and read return delay

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [OFFSET_W-1:0]   offset_t;

    // Low OFFSET_W bits pick the bank
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    typedef logic [LINE_WORDS-1:0] bank_mask_t; // One bit per bank

    // Tag store entry
    // Valid bit is kept by the store itself
    typedef struct packed {
        logic dirty;  // Line differs from memory
        tag_t tag;
    } tag_entry_t;

    // Word 0 in the low bits
    typedef word_t [LINE_WORDS-1:0] line_t;

endpackage

// ==== logic/line_ram.sv ====
module line_ram #(
    parameter type entry_t = logic   // Tag entry or full data line
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rd_en,
    input  logic                 wr_en,
    input  dm_cache_pkg::index_t rd_index,
    input  dm_cache_pkg::index_t wr_index,
    input  entry_t               wr_entry,
    output entry_t               rd_entry,
    output logic                 rd_valid
);
    import dm_cache_pkg::*;

    entry_t               mem [NUM_LINES];  // Payload, no reset
    logic [NUM_LINES-1:0] valid;            // Per entry valid

    // Valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_valid <= valid[rd_index];  // Old value on same-index write
            end
            if (wr_en) begin
                valid[wr_index] <= 1'b1;
            end
        end
    end

    // Entry array, read-first
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_entry <= mem[rd_index];  // Held until next rd_en
        end
        if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

endmodule

// ==== logic/cache_ctrl.sv ====
module cache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd,
    input  logic                     wr,
    input  dm_cache_pkg::addr_t      addr,
    input  dm_cache_pkg::word_t      wdata,
    output dm_cache_pkg::word_t      rdata,
    output logic                     done,
    output logic                     stall,
    output logic                     hit,
    output logic                     tag_rd_en,
    output logic                     tag_wr_en,
    output logic                     data_rd_en,
    output logic                     data_wr_en,
    output dm_cache_pkg::index_t     store_index,
    input  dm_cache_pkg::tag_entry_t tag_entry,
    input  logic                     tag_valid,
    output dm_cache_pkg::tag_entry_t tag_wr_entry,
    input  dm_cache_pkg::line_t      data_line,
    output dm_cache_pkg::line_t      data_wr_line,
    output logic                     mem_rd,
    output logic                     mem_wr,
    output dm_cache_pkg::mem_addr_t  mem_addr,
    output dm_cache_pkg::word_t      mem_wdata,
    input  dm_cache_pkg::bank_mask_t mem_busy,
    input  logic                     mem_rvalid,
    input  dm_cache_pkg::word_t      mem_rdata
);
    import dm_cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,       // Wait for rd or wr
        S_LOOKUP,     // Store read issued
        S_COMPARE,    // Tag compare, done on hit
        S_WRITEBACK,  // Old dirty line out to memory
        S_FILL,       // Four reads issued and collected
        S_UPDATE      // Refilled line written, done
    } state_t;

    state_t            state;
    state_t            state_nxt;
    tag_t              req_tag;
    index_t            req_index;
    offset_t           req_offset;
    logic [OFFSET_W:0] issue_cnt;   // Top bit set once all four issued
    offset_t           ret_cnt;     // Read returns seen so far
    offset_t           issue_bank;
    logic              line_hit;
    logic              store_wr;
    line_t             fill_buf;    // Collected fill words
    line_t             base_line;
    line_t             merged_line;

    // Requester holds addr until done
    assign req_tag    = addr[ADDR_W-1 -: TAG_W];
    assign req_index  = addr[OFFSET_W+1 +: INDEX_W];
    assign req_offset = addr[OFFSET_W:1];  // Bit 0 ignored
    assign issue_bank = issue_cnt[OFFSET_W-1:0];

    assign line_hit = tag_valid && (tag_entry.tag == req_tag);

    // Both stores share index and timing
    assign store_index = req_index;
    assign tag_rd_en   = (state == S_LOOKUP);
    assign data_rd_en  = (state == S_LOOKUP);

    // Write hit in compare, or refill in update
    assign store_wr   = ((state == S_COMPARE) && line_hit && wr) || (state == S_UPDATE);
    assign tag_wr_en  = store_wr;
    assign data_wr_en = store_wr;

    // A write hit already has wr set, so dirty follows wr in both cases
    assign tag_wr_entry = '{dirty: wr, tag: req_tag};

    // Processor handshake
    assign done  = ((state == S_COMPARE) && line_hit) || (state == S_UPDATE);
    assign hit   = (state == S_COMPARE) && line_hit;  // Update is always a miss
    assign stall = (state != S_IDLE) && !done;

    // Line source, then merge of the write word
    always_comb begin
        base_line   = (state == S_UPDATE) ? fill_buf : data_line;
        merged_line = base_line;
        if (wr) begin
            merged_line[req_offset] = wdata;
        end
    end

    assign data_wr_line = merged_line;
    assign rdata        = base_line[req_offset];  // Unmerged word on a read

    // Memory requests, held while the target bank is busy
    always_comb begin
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        mem_addr = {req_tag, req_index, issue_bank};  // Fill address
        if (state == S_WRITEBACK) begin
            mem_wr   = !mem_busy[issue_bank];
            mem_addr = {tag_entry.tag, req_index, issue_bank};  // Old line home
        end else if (state == S_FILL) begin
            mem_rd = !issue_cnt[OFFSET_W] && !mem_busy[issue_bank];
        end
    end

    // Store output holds the old line through writeback
    assign mem_wdata = data_line[issue_bank];

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (rd || wr) begin
                    state_nxt = S_LOOKUP;
                end
            end
            S_LOOKUP: state_nxt = S_COMPARE;
            S_COMPARE: begin
                if (line_hit) begin
                    state_nxt = S_IDLE;
                end else if (tag_valid && tag_entry.dirty) begin
                    state_nxt = S_WRITEBACK;  // Evict first
                end else begin
                    state_nxt = S_FILL;
                end
            end
            S_WRITEBACK: begin
                if (mem_wr && (&issue_bank)) begin
                    state_nxt = S_FILL;  // Last word accepted
                end
            end
            S_FILL: begin
                if (mem_rvalid && (&ret_cnt)) begin
                    state_nxt = S_UPDATE;
                end
            end
            S_UPDATE: state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (state_nxt != state) begin
                // Fresh counts for each phase
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end else begin
                if (mem_rd || mem_wr) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (mem_rvalid) begin
                    ret_cnt <= ret_cnt + 1'b1;
                end
            end
        end
    end

    // Returns arrive in issue order, so the count is the word offset
    always_ff @(posedge clk) begin
        if ((state == S_FILL) && mem_rvalid) begin
            fill_buf[ret_cnt] <= mem_rdata;
        end
    end

endmodule

// ==== logic/banked_mem.sv ====
module banked_mem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mem_rd,
    input  logic                     mem_wr,
    input  dm_cache_pkg::mem_addr_t  mem_addr,
    input  dm_cache_pkg::word_t      mem_wdata,
    output dm_cache_pkg::bank_mask_t mem_busy,
    output logic                     mem_rvalid,
    output dm_cache_pkg::word_t      mem_rdata
);
    import dm_cache_pkg::*;

    typedef logic [$clog2(MEM_LATENCY+1)-1:0] cnt_t;
    typedef logic [MEM_ADDR_W-OFFSET_W-1:0]   row_t;

    word_t                  bank_mem [LINE_WORDS][BANK_DEPTH];  // Contents not reset
    cnt_t                   busy_cnt [LINE_WORDS];
    logic [MEM_LATENCY-1:0] rv_pipe;              // Read return valids
    word_t                  rd_pipe [MEM_LATENCY];
    offset_t                bank_sel;
    row_t                   row;
    logic                   accept;

    assign bank_sel = mem_addr[OFFSET_W-1:0];          // Low bits pick bank
    assign row      = mem_addr[MEM_ADDR_W-1:OFFSET_W];

    // Requests to a busy bank are dropped
    assign accept = (mem_rd || mem_wr) && !mem_busy[bank_sel];

    always_comb begin
        for (int b = 0; b < LINE_WORDS; b++) begin
            mem_busy[b] = (busy_cnt[b] != '0);
        end
    end

    // Busy counters and return valids
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < LINE_WORDS; b++) begin
                busy_cnt[b] <= '0;
            end
            rv_pipe <= '0;
        end else begin
            for (int b = 0; b < LINE_WORDS; b++) begin
                if (accept && (bank_sel == offset_t'(b))) begin
                    busy_cnt[b] <= cnt_t'(MEM_LATENCY);  // Busy next MEM_LATENCY cycles
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;
                end
            end
            rv_pipe <= {rv_pipe[MEM_LATENCY-2:0], accept && mem_rd};
        end
    end

    // Array access and read data shift
    always_ff @(posedge clk) begin
        if (accept && mem_wr) begin
            bank_mem[bank_sel][row] <= mem_wdata;
        end
        rd_pipe[0] <= bank_mem[bank_sel][row];  // Sampled at accept
        for (int i = 1; i < MEM_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // Out MEM_LATENCY cycles after accept
    assign mem_rvalid = rv_pipe[MEM_LATENCY-1];
    assign mem_rdata  = rd_pipe[MEM_LATENCY-1];

endmodule

// ==== logic/dm_cache.sv ====
module dm_cache (
    input  logic                clk,
    input  logic                rst_n,
    input  dm_cache_pkg::addr_t addr,
    input  dm_cache_pkg::word_t wdata,
    input  logic                rd,
    input  logic                wr,
    output dm_cache_pkg::word_t rdata,
    output logic                done,
    output logic                stall,
    output logic                hit
);
    import dm_cache_pkg::*;

    // Store side
    logic       tag_rd_en;
    logic       tag_wr_en;
    logic       data_rd_en;
    logic       data_wr_en;
    index_t     store_index;   // Shared by both stores
    tag_entry_t tag_entry;
    logic       tag_valid;
    tag_entry_t tag_wr_entry;
    line_t      data_line;
    line_t      data_wr_line;

    // Memory side
    logic       mem_rd;
    logic       mem_wr;
    mem_addr_t  mem_addr;
    word_t      mem_wdata;
    bank_mask_t mem_busy;
    logic       mem_rvalid;
    word_t      mem_rdata;

    // Dirty flag and tag per line
    line_ram #(.entry_t(tag_entry_t)) tag_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (tag_rd_en),
        .wr_en    (tag_wr_en),
        .rd_index (store_index),
        .wr_index (store_index),
        .wr_entry (tag_wr_entry),
        .rd_entry (tag_entry),
        .rd_valid (tag_valid)
    );

    // Valid is taken from the tag store
    line_ram #(.entry_t(line_t)) data_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (data_rd_en),
        .wr_en    (data_wr_en),
        .rd_index (store_index),
        .wr_index (store_index),
        .wr_entry (data_wr_line),
        .rd_entry (data_line),
        .rd_valid ()
    );

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd           (rd),
        .wr           (wr),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .done         (done),
        .stall        (stall),
        .hit          (hit),
        .tag_rd_en    (tag_rd_en),
        .tag_wr_en    (tag_wr_en),
        .data_rd_en   (data_rd_en),
        .data_wr_en   (data_wr_en),
        .store_index  (store_index),
        .tag_entry    (tag_entry),
        .tag_valid    (tag_valid),
        .tag_wr_entry (tag_wr_entry),
        .data_line    (data_line),
        .data_wr_line (data_wr_line),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_busy     (mem_busy),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata)
    );

    banked_mem u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_busy   (mem_busy),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

endmodule

// ==== test/dm_cache_checker.sv ====
module dm_cache_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     done,
    input logic                     stall,
    input logic                     mem_rd,
    input logic                     mem_wr,
    input dm_cache_pkg::mem_addr_t  mem_addr,
    input dm_cache_pkg::bank_mask_t mem_busy
);
    timeunit 1ns;
    timeprecision 1ps;

    import dm_cache_pkg::*;

    // One count per property, summed for the testbench
    int done_fails;
    int excl_fails;
    int busy_fails;
    int stall_fails;
    int fail_cnt;

    assign fail_cnt = done_fails + excl_fails + busy_fails + stall_fails;

    // Done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            done_fails++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr))
        else begin
            $error("mem_rd and mem_wr high together");
            excl_fails++;
        end

    // Target bank from the low address bits
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_rd || mem_wr) |-> !mem_busy[mem_addr[OFFSET_W-1:0]])
        else begin
            $error("memory request to a busy bank");
            busy_fails++;
        end

    // Stall runs up to the done cycle and drops there
    assert property (@(posedge clk) disable iff (!rst_n) done |-> $fell(stall))
        else begin
            $error("stall did not fall in the done cycle");
            stall_fails++;
        end

endmodule

bind cache_ctrl dm_cache_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .done     (done),
    .stall    (stall),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr),
    .mem_addr (mem_addr),
    .mem_busy (mem_busy)
);

// ==== test/dm_cache_tb.sv ====
module dm_cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dm_cache_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 3;
    localparam int MISS_CYCLES  = 20;    // Worst-case miss
    localparam int RAND_OPS     = 200;
    localparam int NUM_OPS      = 16 + RAND_OPS;  // Directed ops plus random ops
    localparam int HIT_LATENCY  = 2;     // Sample edge to done

    logic  clk;
    logic  rst_n;
    addr_t addr;
    word_t wdata;
    logic  rd;
    logic  wr;
    word_t rdata;
    logic  done;
    logic  stall;
    logic  hit;

    word_t ref_mem [mem_addr_t];         // Expected memory image, by word address
    logic  line_present [NUM_LINES];     // Expected tag store contents
    tag_t  line_tag [NUM_LINES];
    int    last_latency;                 // Cycles from sample edge to done

    dm_cache u_dm_cache (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .wdata (wdata),
        .rd    (rd),
        .wr    (wr),
        .rdata (rdata),
        .done  (done),
        .stall (stall),
        .hit   (hit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog, every op budgeted as a worst-case miss plus handshake
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_OPS * (MISS_CYCLES + 3) + 50));
        $display("Timeout: the tests did not finish in the expected time");
        fail_run();
    end

    // Handshake assertions in the controller
    initial begin
        wait (u_dm_cache.u_ctrl.u_checker.fail_cnt != 0);
        $display("A handshake assertion in the controller failed");
        fail_run();
    end

    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_word(input addr_t a, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error: rdata at addr 0x%h: got 0x%h, expected 0x%h", a, got, exp);
            fail_run();
        end
    endtask

    task automatic check_hit(input addr_t a, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: hit at addr 0x%h: got 0x%h, expected 0x%h", a, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("Error: hit latency: got 0x%h, expected 0x%h", got, exp);
            fail_run();
        end
    endtask

    function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
        return {t, i, o, 1'b0};  // Bit 0 unused
    endfunction

    // Direct mapped, so one tag per index
    function automatic logic predict_hit(input addr_t a);
        index_t i;
        i = a[OFFSET_W+1 +: INDEX_W];
        return line_present[i] && (line_tag[i] == a[ADDR_W-1 -: TAG_W]);
    endfunction

    function automatic void note_line(input addr_t a);
        line_present[a[OFFSET_W+1 +: INDEX_W]] = 1'b1;
        line_tag[a[OFFSET_W+1 +: INDEX_W]]     = a[ADDR_W-1 -: TAG_W];
    endfunction

    // One request, held until done, dropped the cycle after
    task automatic access(input logic is_wr, input addr_t a, input word_t d,
                          output word_t got, output logic got_hit);
        int cycles;
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        rd    <= !is_wr;
        wr    <= is_wr;
        cycles = 0;
        do begin
            @(negedge clk);  // Outputs settled here
            cycles++;
            if (cycles > 2 * MISS_CYCLES) begin
                $display("No done from the cache within %0d cycles, addr 0x%h", cycles, a);
                fail_run();
            end
            if (!done) begin
                check_flag("stall", stall, cycles > 1);  // High once the request is sampled
            end
        end while (!done);
        check_flag("stall", stall, 1'b0);  // Low in the done cycle
        got          = rdata;
        got_hit      = hit;
        last_latency = cycles - 1;  // First edge is the sample edge
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
    endtask

    task automatic read_word(input addr_t a);
        word_t got;
        logic  got_hit;
        logic  exp_hit;
        exp_hit = predict_hit(a);
        access(1'b0, a, '0, got, got_hit);
        check_hit(a, got_hit, exp_hit);
        if (ref_mem.exists(a[ADDR_W-1:1])) begin
            check_word(a, got, ref_mem[a[ADDR_W-1:1]]);  // Only written words
        end
        note_line(a);
    endtask

    task automatic write_word(input addr_t a, input word_t d);
        word_t got;
        logic  got_hit;
        logic  exp_hit;
        exp_hit = predict_hit(a);
        access(1'b1, a, d, got, got_hit);
        check_hit(a, got_hit, exp_hit);
        ref_mem[a[ADDR_W-1:1]] = d;
        note_line(a);
    endtask

    task automatic test_reset();
        repeat (4) begin
            @(negedge clk);
            check_flag("done", done, 1'b0);
            check_flag("stall", stall, 1'b0);
        end
        read_word(make_addr(5'h03, 8'h10, 2'd1));  // Empty cache, miss
    endtask

    task automatic test_write_then_read();
        addr_t a;
        a = make_addr(5'h01, 8'h22, 2'd2);
        write_word(a, 16'hbeef);
        read_word(a);
        check_latency(last_latency, HIT_LATENCY);
    endtask

    task automatic test_line_merge();
        for (int o = 0; o < LINE_WORDS; o++) begin
            write_word(make_addr(5'h02, 8'h40, offset_t'(o)), word_t'(32'h3a00 + o));
        end
        write_word(make_addr(5'h02, 8'h40, 2'd1), 16'h5c5c);  // One word replaced
        for (int o = 0; o < LINE_WORDS; o++) begin
            read_word(make_addr(5'h02, 8'h40, offset_t'(o)));
        end
    endtask

    // B evicts dirty A, then A evicts dirty B
    task automatic test_dirty_evict();
        write_word(make_addr(5'h04, 8'h55, 2'd0), 16'h1234);
        write_word(make_addr(5'h09, 8'h55, 2'd3), 16'h5678);
        read_word(make_addr(5'h04, 8'h55, 2'd0));
        read_word(make_addr(5'h09, 8'h55, 2'd3));
    endtask

    task automatic test_random();
        tag_t    t;
        index_t  i;
        offset_t o;
        for (int n = 0; n < RAND_OPS; n++) begin
            t = ($urandom % 2 == 0) ? 5'h06 : 5'h1b;  // Two tags fight per index
            i = index_t'(32'h80 + ($urandom % 4));
            o = offset_t'($urandom % 4);
            if ($urandom % 2 == 0) begin
                write_word(make_addr(t, i, o), word_t'($urandom));
            end else begin
                read_word(make_addr(t, i, o));
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        rd    = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int n = 0; n < NUM_LINES; n++) begin
            line_present[n] = 1'b0;
            line_tag[n]     = '0;
        end
        void'($urandom(32'h0afd_64f5));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_write_then_read();
        test_line_merge();
        test_dirty_evict();
        test_random();
        repeat (2) @(posedge clk);  // Let the last assertions sample
        if (u_dm_cache.u_ctrl.u_checker.fail_cnt != 0) begin
            $display("Handshake assertions failed %0d times",
                     u_dm_cache.u_ctrl.u_checker.fail_cnt);
            fail_run();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== dm_cache.f ====
logic/dm_cache_pkg.sv
logic/line_ram.sv
logic/cache_ctrl.sv
logic/banked_mem.sv
logic/dm_cache.sv
test/dm_cache_checker.sv
test/dm_cache_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
TOP        = dm_cache_tb
FILELIST   = dm_cache.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Everything OK
RUN_OPTS   = +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_OPTS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
